//--- tb.f
hw/sv32_pkg.sv
hw/mem_port_pkg.sv
hw/fetch_translate.sv
hw/data_translate.sv
hw/page_walker.sv
hw/mem_port_mux.sv
hw/sv32_mmu.sv
bench/clk_gen.sv
bench/mmu_tb.sv

//--- Bender.yml
package:
  name: sv32_mmu

sources:
  - hw/sv32_pkg.sv
  - hw/mem_port_pkg.sv
  - hw/fetch_translate.sv
  - hw/data_translate.sv
  - hw/page_walker.sv
  - hw/mem_port_mux.sv
  - hw/sv32_mmu.sv
  - target: simulation
    files:
      - bench/clk_gen.sv
      - bench/mmu_tb.sv

//--- bench/mmu_tb.sv
// MMU testbench
module mmu_tb;
    import sv32_pkg::*;
    import mem_port_pkg::*;

    localparam int          CYCLE_LIMIT = 4000;
    localparam logic [31:0] ROOT        = 32'h0010_0000;
    localparam logic [9:0]  F_V  = 10'h001;
    localparam logic [9:0]  F_R  = 10'h002;
    localparam logic [9:0]  F_W  = 10'h004;
    localparam logic [9:0]  F_X  = 10'h008;
    localparam logic [9:0]  F_U  = 10'h010;
    localparam logic [9:0]  F_AD = 10'h0c0;

    logic         clk;
    logic         rst;
    satp_t        satp;
    priv_t        priv_d;
    logic         sum;
    logic         mxr;
    logic         flush;
    fetch_req_t   fetch_req;
    logic         fetch_accept;
    fetch_out_t   fetch_out;
    logic         fetch_fault;
    lsu_req_t     lsu_req;
    logic         lsu_accept;
    lsu_rsp_t     lsu_rsp;
    lsu_req_t     mem_req;
    logic         mem_accept;
    mem_rsp_t     mem_rsp;

    // Memory model state
    logic [31:0]  mem_q [logic [31:0]];
    logic [31:0]  walk_log [$];
    lsu_req_t     core_log [$];
    logic         rsp_pend_q;
    mem_rsp_t     rsp_q;
    logic         held_q;
    lsu_req_t     held_req_q;

    int           checks;
    int           errors;
    int           tests;
    int           err_base;
    int           stalls;
    int           cycles;
    lsu_rsp_t     rsp;
    logic [31:0]  phys;
    logic         fetch_rd;
    logic [31:0]  va;
    logic [31:0]  pc;
    logic [9:0]   vpn0;
    logic [11:0]  off;
    logic         flt;

    clk_gen clk_gen_i
    (
        .clk_o (clk),
        .rst_o (rst)
    );

    sv32_mmu sv32_mmu_i
    (
        .clk_i              (clk),
        .rst_i              (rst),
        .satp_i             (satp),
        .priv_d_i           (priv_d),
        .sum_i              (sum),
        .mxr_i              (mxr),
        .flush_i            (flush),
        .fetch_req_i        (fetch_req),
        .fetch_accept_o     (fetch_accept),
        .fetch_out_o        (fetch_out),
        .fetch_out_accept_i (1'b1),
        .fetch_fault_o      (fetch_fault),
        .lsu_req_i          (lsu_req),
        .lsu_accept_o       (lsu_accept),
        .lsu_rsp_o          (lsu_rsp),
        .mem_req_o          (mem_req),
        .mem_accept_i       (mem_accept),
        .mem_rsp_i          (mem_rsp)
    );

    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [9:0] flags);
        return {ppn, flags};
    endfunction

    // Unwritten words read back a pattern of their address
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem_q.exists(addr))
            return mem_q[addr];
        return addr ^ 32'hc3a5_5a3c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic send_fetch(input logic [31:0] addr, input priv_t priv,
                              output logic [31:0] out_pc, output logic out_rd,
                              output logic fault);
        @(negedge clk);
        fetch_req = '{rd: 1'b1, pc: addr, priv: priv};
        do @(posedge clk); while (!fetch_accept);
        out_pc = fetch_out.pc;
        out_rd = fetch_out.rd;
        @(negedge clk);
        fetch_req.rd = 1'b0;
        @(posedge clk);
        fault = fetch_fault;
    endtask

    task automatic lsu_access(input logic rd, input logic [3:0] wr, input logic [31:0] addr,
                              input logic [10:0] tag, output lsu_rsp_t result);
        @(negedge clk);
        lsu_req = '{rd: rd, wr: wr, addr: addr, data_wr: ~addr, tag: tag};
        do @(posedge clk); while (!lsu_accept);
        @(negedge clk);
        lsu_req = '0;
        do @(posedge clk); while (!lsu_rsp.rsp.ack);
        result = lsu_rsp;
    endtask

    task automatic start_test();
        err_base = errors;
        walk_log.delete();
        core_log.delete();
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_base);
    endtask

    //------------------------------------------------------------------
    // Memory model
    //------------------------------------------------------------------
    always @(posedge clk)
    begin
        if (!rst && (mem_req.rd || (|mem_req.wr)) && mem_accept)
        begin
            if (mem_req.tag == WALK_TAG)
                walk_log.push_back(mem_req.addr);
            else
                core_log.push_back(mem_req);
            rsp_pend_q <= 1'b1;
            rsp_q      <= '{ack: 1'b1, error: 1'b0, data: read_word(mem_req.addr),
                            tag: mem_req.tag};
            if (|mem_req.wr)
                mem_q[mem_req.addr] = mem_req.data_wr;
        end
        else
            rsp_pend_q <= 1'b0;
    end

    always @(negedge clk)
    begin
        mem_rsp    <= rsp_pend_q ? rsp_q : '0;
        mem_accept <= ($urandom % 4) != 0;
    end

    // Request must hold still while the port stalls
    always @(posedge clk)
    begin
        if (!rst && held_q)
        begin
            stalls++;
            checks++;
            assert (mem_req === held_req_q)
            else
            begin
                $display("error: mem_req_o got %h expected %h", mem_req, held_req_q);
                errors++;
            end
        end
        held_q     <= !rst && (mem_req.rd || (|mem_req.wr)) && !mem_accept;
        held_req_q <= mem_req;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    //------------------------------------------------------------------
    // Tests
    //------------------------------------------------------------------
    initial
    begin
        void'($urandom(32'hdec3_d106));
        satp       = '0;
        priv_d     = PRIV_SUPER;
        sum        = 1'b0;
        mxr        = 1'b0;
        flush      = 1'b0;
        fetch_req  = '0;
        lsu_req    = '0;
        mem_accept = 1'b0;
        mem_rsp    = '0;
        rsp_pend_q = 1'b0;
        rsp_q      = '0;
        held_q     = 1'b0;
        held_req_q = '0;
        checks     = 0;
        errors     = 0;
        tests      = 0;
        stalls     = 0;
        cycles     = 0;

        // Small page table, one root entry per test region
        mem_q[ROOT + 4]          = make_pte(22'h00101, F_V);
        mem_q[32'h0010_1004]     = make_pte(22'h00200, F_V | F_R | F_X | F_AD);
        mem_q[ROOT + 8]          = make_pte(22'h00c00, F_V | F_R | F_W | F_AD);
        mem_q[ROOT + 12]         = make_pte(22'h01000, F_V | F_R | F_X | F_U | F_AD);
        mem_q[ROOT + 16]         = make_pte(22'h01400, F_V | F_R | F_AD);
        mem_q[ROOT + 20]         = make_pte(22'h01800, F_V | F_X | F_AD);
        mem_q[ROOT + 24]         = make_pte(22'h01c00, F_V | F_R | F_W | F_U | F_AD);
        mem_q[ROOT + 28]         = 32'h0;
        @(negedge rst);

        // Bare mode, then machine mode with translation on
        start_test();
        pc = $urandom & 32'hffff_fffc;
        send_fetch(pc, PRIV_SUPER, phys, fetch_rd, flt);
        check_value("fetch_out_o.pc", phys, pc);
        va = $urandom & 32'hffff_fffc;
        lsu_access(1'b1, 4'h0, va, 11'h011, rsp);
        check_value("mem_req_o.addr", core_log[0].addr, va);
        check_value("lsu_rsp_o.data", rsp.rsp.data, read_word(va));
        @(negedge clk);
        satp   = '{mode: 1'b1, asid: 9'h0, ppn: 22'(ROOT >> 12)};
        priv_d = PRIV_MACHINE;
        pc = $urandom & 32'hffff_fffc;
        send_fetch(pc, PRIV_MACHINE, phys, fetch_rd, flt);
        check_value("fetch_out_o.pc", phys, pc);
        va = $urandom & 32'hffff_fffc;
        lsu_access(1'b1, 4'h0, va, 11'h012, rsp);
        check_value("mem_req_o.addr", core_log[1].addr, va);
        check_value("walker reads", walk_log.size(), 0);
        end_test("bare and machine mode");

        // Two-level fetch walk
        start_test();
        @(negedge clk);
        priv_d = PRIV_SUPER;
        off = 12'($urandom) & 12'hffc;
        send_fetch({10'd1, 10'd1, off}, PRIV_SUPER, phys, fetch_rd, flt);
        check_value("walker reads", walk_log.size(), 2);
        check_value("walk_addr level 1", walk_log[0], ROOT + 4);
        check_value("walk_addr level 2", walk_log[1], 32'h0010_1004);
        check_value("fetch_out_o.pc", phys, {20'h00200, off});
        check_value("fetch_out_o.rd", fetch_rd, 1);
        check_value("fetch_fault_o", flt, 0);
        end_test("fetch walk");

        // Superpage load
        start_test();
        vpn0 = 10'($urandom);
        off  = 12'($urandom) & 12'hffc;
        lsu_access(1'b1, 4'h0, {10'd2, vpn0, off}, 11'h055, rsp);
        check_value("walker reads", walk_log.size(), 1);
        check_value("walk_addr", walk_log[0], ROOT + 8);
        check_value("mem_req_o.addr", core_log[0].addr, {10'd3, vpn0, off});
        check_value("lsu_rsp_o.data", rsp.rsp.data, read_word({10'd3, vpn0, off}));
        check_value("lsu_rsp_o.tag", rsp.rsp.tag, 11'h055);
        end_test("superpage load");

        // Permission faults
        start_test();
        send_fetch({10'd3, 10'($urandom), 12'h100}, PRIV_SUPER, phys, fetch_rd, flt);
        check_value("fetch_fault_o", flt, 1);
        check_value("fetch_out_o.rd", fetch_rd, 0);
        lsu_access(1'b0, 4'hf, {10'd4, 10'($urandom), 12'h040}, 11'h021, rsp);
        check_value("lsu_rsp_o.store_fault", rsp.store_fault, 1);
        check_value("lsu_rsp_o.error", rsp.rsp.error, 1);
        check_value("memory writes", core_log.size(), 0);
        va = {10'd5, 10'($urandom), 12'h080};
        lsu_access(1'b1, 4'h0, va, 11'h022, rsp);
        check_value("lsu_rsp_o.load_fault", rsp.load_fault, 1);
        @(negedge clk);
        mxr = 1'b1;
        lsu_access(1'b1, 4'h0, va, 11'h023, rsp);
        check_value("lsu_rsp_o.load_fault", rsp.load_fault, 0);
        check_value("lsu_rsp_o.error", rsp.rsp.error, 0);
        @(negedge clk);
        mxr = 1'b0;
        va = {10'd6, 10'($urandom), 12'h0c0};
        lsu_access(1'b1, 4'h0, va, 11'h024, rsp);
        check_value("lsu_rsp_o.load_fault", rsp.load_fault, 1);
        @(negedge clk);
        sum = 1'b1;
        lsu_access(1'b1, 4'h0, va, 11'h025, rsp);
        check_value("lsu_rsp_o.load_fault", rsp.load_fault, 0);
        lsu_access(1'b0, 4'hf, va, 11'h026, rsp);
        check_value("lsu_rsp_o.store_fault", rsp.store_fault, 0);
        check_value("mem_req_o.wr", core_log[2].wr, 4'hf);
        check_value("mem_req_o.addr", core_log[2].addr, {10'd7, va[21:0]});
        check_value("mem_req_o.data_wr", core_log[2].data_wr, ~va);
        @(negedge clk);
        sum = 1'b0;
        end_test("permission faults");

        // Invalid PTE
        start_test();
        lsu_access(1'b1, 4'h0, {10'd7, 10'($urandom), 12'h010}, 11'h031, rsp);
        check_value("lsu_rsp_o.load_fault", rsp.load_fault, 1);
        check_value("walker reads", walk_log.size(), 1);
        check_value("core requests", core_log.size(), 0);
        end_test("invalid pte");

        // Flush and back-pressure
        start_test();
        va = {10'd2, 10'($urandom), 12'h200};
        lsu_access(1'b1, 4'h0, va, 11'h041, rsp);
        check_value("walker reads", walk_log.size(), 1);
        walk_log.delete();
        lsu_access(1'b1, 4'h0, va, 11'h042, rsp);
        check_value("walker reads", walk_log.size(), 0);
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        lsu_access(1'b1, 4'h0, va, 11'h043, rsp);
        check_value("walker reads", walk_log.size(), 1);
        check_value("stalled cycles seen", stalls != 0, 1);
        end_test("flush and back-pressure");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- bench/clk_gen.sv
// Testbench clock and reset
module clk_gen
(
    output logic clk_o,
    output logic rst_o
);
    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 5;

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial
    begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

//--- hw/sv32_mmu.sv
// Sv32 MMU top level
module sv32_mmu
(
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  sv32_pkg::satp_t          satp_i,
    input  sv32_pkg::priv_t          priv_d_i,
    input  logic                     sum_i,
    input  logic                     mxr_i,
    input  logic                     flush_i,
    input  mem_port_pkg::fetch_req_t fetch_req_i,
    output logic                     fetch_accept_o,
    output mem_port_pkg::fetch_out_t fetch_out_o,
    input  logic                     fetch_out_accept_i,
    output logic                     fetch_fault_o,
    input  mem_port_pkg::lsu_req_t   lsu_req_i,
    output logic                     lsu_accept_o,
    output mem_port_pkg::lsu_rsp_t   lsu_rsp_o,
    output mem_port_pkg::lsu_req_t   mem_req_o,
    input  logic                     mem_accept_i,
    input  mem_port_pkg::mem_rsp_t   mem_rsp_i
);
    import sv32_pkg::*;
    import mem_port_pkg::*;

    logic         i_miss;
    logic [31:0]  i_addr;
    logic         d_miss;
    logic [31:0]  d_addr;
    logic         i_refill;
    logic         d_refill;
    tlb_entry_t   refill_entry;
    logic         walk_req;
    logic [31:0]  walk_addr;
    logic         walk_accept;
    walk_rsp_t    walk_rsp;
    logic         port_accept;
    lsu_req_t     cpu_req;
    mem_rsp_t     cpu_rsp;

    fetch_translate fetch_translate_i
    (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .satp_i             (satp_i),
        .flush_i            (flush_i),
        .fetch_req_i        (fetch_req_i),
        .fetch_out_accept_i (fetch_out_accept_i),
        .refill_i           (i_refill),
        .refill_entry_i     (refill_entry),
        .fetch_accept_o     (fetch_accept_o),
        .fetch_out_o        (fetch_out_o),
        .fetch_fault_o      (fetch_fault_o),
        .miss_o             (i_miss),
        .miss_addr_o        (i_addr)
    );

    data_translate data_translate_i
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .satp_i         (satp_i),
        .priv_d_i       (priv_d_i),
        .sum_i          (sum_i),
        .mxr_i          (mxr_i),
        .flush_i        (flush_i),
        .lsu_req_i      (lsu_req_i),
        .refill_i       (d_refill),
        .refill_entry_i (refill_entry),
        .port_accept_i  (port_accept),
        .cpu_rsp_i      (cpu_rsp),
        .lsu_accept_o   (lsu_accept_o),
        .lsu_rsp_o      (lsu_rsp_o),
        .cpu_req_o      (cpu_req),
        .miss_o         (d_miss),
        .miss_addr_o    (d_addr)
    );

    page_walker page_walker_i
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .satp_i         (satp_i),
        .i_miss_i       (i_miss),
        .i_addr_i       (i_addr),
        .d_miss_i       (d_miss),
        .d_addr_i       (d_addr),
        .walk_accept_i  (walk_accept),
        .walk_rsp_i     (walk_rsp),
        .walk_req_o     (walk_req),
        .walk_addr_o    (walk_addr),
        .i_refill_o     (i_refill),
        .d_refill_o     (d_refill),
        .refill_entry_o (refill_entry)
    );

    mem_port_mux mem_port_mux_i
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .walk_req_i    (walk_req),
        .walk_addr_i   (walk_addr),
        .cpu_req_i     (cpu_req),
        .mem_accept_i  (mem_accept_i),
        .mem_rsp_i     (mem_rsp_i),
        .walk_accept_o (walk_accept),
        .port_accept_o (port_accept),
        .walk_rsp_o    (walk_rsp),
        .cpu_rsp_o     (cpu_rsp),
        .mem_req_o     (mem_req_o)
    );

endmodule

//--- hw/mem_port_mux.sv
// Shared memory port arbiter
module mem_port_mux
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    walk_req_i,
    input  logic [31:0]             walk_addr_i,
    input  mem_port_pkg::lsu_req_t  cpu_req_i,
    input  logic                    mem_accept_i,
    input  mem_port_pkg::mem_rsp_t  mem_rsp_i,
    output logic                    walk_accept_o,
    output logic                    port_accept_o,
    output mem_port_pkg::walk_rsp_t walk_rsp_o,
    output mem_port_pkg::mem_rsp_t  cpu_rsp_o,
    output mem_port_pkg::lsu_req_t  mem_req_o
);
    import mem_port_pkg::*;

    lsu_req_t  walk_mem_w;
    logic      hold_q;
    logic      src_walk_q;
    logic      src_walk_w;
    logic      is_walk_w;

    // Walker reads never write
    assign walk_mem_w = '{rd: walk_req_i, wr: 4'b0, addr: walk_addr_i,
                          data_wr: 32'b0, tag: WALK_TAG};

    //------------------------------------------------------------------
    // Source select
    //------------------------------------------------------------------
    // Both sources keep their request up until it is taken, so freezing
    // the select is enough to keep the port stable
    assign src_walk_w = hold_q ? src_walk_q : walk_req_i;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            hold_q     <= 1'b0;
            src_walk_q <= 1'b0;
        end
        else if ((mem_req_o.rd || (|mem_req_o.wr)) && !mem_accept_i)
        begin
            hold_q     <= 1'b1;
            src_walk_q <= src_walk_w;
        end
        else if (mem_accept_i)
            hold_q <= 1'b0;
    end

    assign mem_req_o     = src_walk_w ? walk_mem_w : cpu_req_i;
    assign walk_accept_o = src_walk_w & mem_accept_i;
    assign port_accept_o = ~src_walk_w & mem_accept_i;

    //------------------------------------------------------------------
    // Response steering by tag
    //------------------------------------------------------------------
    assign is_walk_w = (mem_rsp_i.tag == WALK_TAG);

    assign walk_rsp_o = '{valid: is_walk_w & (mem_rsp_i.ack | mem_rsp_i.error),
                          error: is_walk_w & mem_rsp_i.error,
                          data:  mem_rsp_i.data};

    assign cpu_rsp_o = '{ack:   ~is_walk_w & mem_rsp_i.ack,
                         error: ~is_walk_w & mem_rsp_i.error,
                         data:  mem_rsp_i.data,
                         tag:   mem_rsp_i.tag};

endmodule

//--- hw/page_walker.sv
// Two-level page table walker
module page_walker
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  sv32_pkg::satp_t         satp_i,
    input  logic                    i_miss_i,
    input  logic [31:0]             i_addr_i,
    input  logic                    d_miss_i,
    input  logic [31:0]             d_addr_i,
    input  logic                    walk_accept_i,
    input  mem_port_pkg::walk_rsp_t walk_rsp_i,
    output logic                    walk_req_o,
    output logic [31:0]             walk_addr_o,
    output logic                    i_refill_o,
    output logic                    d_refill_o,
    output sv32_pkg::tlb_entry_t    refill_entry_o
);
    import sv32_pkg::*;

    typedef enum logic [1:0]
    {
        WALK_IDLE,
        WALK_LEVEL1,
        WALK_LEVEL2,
        WALK_UPDATE
    } walk_state_t;

    walk_state_t  state_q;
    logic         req_q;
    logic         dside_q;
    vaddr_t       va_q;
    vaddr_t       start_va_w;
    logic [31:0]  pte_addr_q;
    pte_t         entry_q;
    pte_t         pte_w;
    logic         start_w;
    logic         bad_w;
    logic         leaf_w;
    logic         descend_w;

    // Table base plus index scaled to bytes
    function automatic logic [31:0] pte_addr(input logic [PPN_W-1:0] ppn,
                                             input logic [VPN_W-1:0] vpn);
        return {ppn[31-PAGE_OFFSET_W:0], {PAGE_OFFSET_W{1'b0}}} +
               (32'(vpn) << PTE_BYTES_SHIFT);
    endfunction

    assign pte_w      = walk_rsp_i.data;
    assign start_va_w = d_miss_i ? d_addr_i : i_addr_i;

    // Data side wins when both miss
    assign start_w   = (state_q == WALK_IDLE) & (d_miss_i | i_miss_i);
    assign bad_w     = walk_rsp_i.error | ~pte_w.flags.v;
    assign leaf_w    = pte_w.flags.r | pte_w.flags.w | pte_w.flags.x;
    assign descend_w = (state_q == WALK_LEVEL1) & walk_rsp_i.valid & ~bad_w & ~leaf_w;

    //------------------------------------------------------------------
    // Walk sequence
    //------------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            state_q <= WALK_IDLE;
            req_q   <= 1'b0;
            dside_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                WALK_IDLE:
                begin
                    if (start_w)
                    begin
                        state_q <= WALK_LEVEL1;
                        dside_q <= d_miss_i;
                    end
                end
                WALK_LEVEL1:
                begin
                    if (walk_rsp_i.valid)
                        state_q <= descend_w ? WALK_LEVEL2 : WALK_UPDATE;
                end
                WALK_LEVEL2:
                begin
                    if (walk_rsp_i.valid)
                        state_q <= WALK_UPDATE;
                end
                default:
                    state_q <= WALK_IDLE;
            endcase

            if (start_w || descend_w)
                req_q <= 1'b1;
            else if (walk_accept_i)
                req_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (start_w)
        begin
            va_q       <= start_va_w;
            pte_addr_q <= pte_addr(satp_i.ppn, start_va_w.vpn1);
        end
        else if (descend_w)
            pte_addr_q <= pte_addr({pte_w.ppn1, pte_w.ppn0}, va_q.vpn0);

        if (walk_rsp_i.valid && state_q != WALK_IDLE)
        begin
            if (bad_w)
                entry_q <= '0;
            else if (state_q == WALK_LEVEL1)
                entry_q <= '{ppn1: pte_w.ppn1, ppn0: va_q.vpn0, flags: pte_w.flags};
            else
                entry_q <= pte_w;
        end
    end

    assign walk_req_o  = req_q;
    assign walk_addr_o = pte_addr_q;

    // One-cycle refill broadcast
    assign i_refill_o     = (state_q == WALK_UPDATE) & ~dside_q;
    assign d_refill_o     = (state_q == WALK_UPDATE) & dside_q;
    assign refill_entry_o = '{valid: 1'b1, vtag: {va_q.vpn1, va_q.vpn0}, pte: entry_q};

endmodule

//--- hw/data_translate.sv
// Load/store address translation
module data_translate
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  sv32_pkg::satp_t         satp_i,
    input  sv32_pkg::priv_t         priv_d_i,
    input  logic                    sum_i,
    input  logic                    mxr_i,
    input  logic                    flush_i,
    input  mem_port_pkg::lsu_req_t  lsu_req_i,
    input  logic                    refill_i,
    input  sv32_pkg::tlb_entry_t    refill_entry_i,
    input  logic                    port_accept_i,
    input  mem_port_pkg::mem_rsp_t  cpu_rsp_i,
    output logic                    lsu_accept_o,
    output mem_port_pkg::lsu_rsp_t  lsu_rsp_o,
    output mem_port_pkg::lsu_req_t  cpu_req_o,
    output logic                    miss_o,
    output logic [31:0]             miss_addr_o
);
    import sv32_pkg::*;
    import mem_port_pkg::*;

    tlb_entry_t        tlb_q;
    lsu_req_t          req_q;
    lsu_req_t          cur_w;
    logic              pend_q;
    logic              new_w;
    logic              valid_w;
    logic              vm_en_w;
    logic              hit_w;
    logic              user_ok_w;
    logic              go_w;
    logic              load_fault_w;
    logic              store_fault_w;
    logic              load_fault_q;
    logic              store_fault_q;
    logic              fault_rsp_w;
    logic [TAG_W-1:0]  fault_tag_q;

    //------------------------------------------------------------------
    // Pending request
    //------------------------------------------------------------------
    assign new_w   = lsu_req_i.rd | (|lsu_req_i.wr);
    assign cur_w   = new_w ? lsu_req_i : req_q;
    assign valid_w = new_w | pend_q;

    assign vm_en_w = satp_i.mode & (priv_d_i != PRIV_MACHINE);
    assign hit_w   = tlb_q.valid & (tlb_q.vtag == cur_w.addr[31:PAGE_OFFSET_W]);

    //------------------------------------------------------------------
    // Permission checks
    //------------------------------------------------------------------
    // User pages reachable from supervisor only under SUM
    assign user_ok_w = (priv_d_i == PRIV_SUPER) ? (~tlb_q.pte.flags.u | sum_i) :
                                                  tlb_q.pte.flags.u;

    assign load_fault_w  = vm_en_w & valid_w & cur_w.rd & hit_w &
        ~(user_ok_w & (tlb_q.pte.flags.r | (mxr_i & tlb_q.pte.flags.x)));
    assign store_fault_w = vm_en_w & valid_w & (|cur_w.wr) & hit_w &
        ~(user_ok_w & tlb_q.pte.flags.r & tlb_q.pte.flags.w);

    assign go_w = valid_w & (~vm_en_w | (hit_w & ~load_fault_w & ~store_fault_w));

    assign cpu_req_o = '{
        rd:      cur_w.rd & go_w,
        wr:      cur_w.wr & {4{go_w}},
        addr:    vm_en_w ? {tlb_q.pte.ppn1[VPN_W-1:0], tlb_q.pte.ppn0,
                            cur_w.addr[PAGE_OFFSET_W-1:0]} : cur_w.addr,
        data_wr: cur_w.data_wr,
        tag:     cur_w.tag
    };

    assign lsu_accept_o = load_fault_w | store_fault_w |
                          (port_accept_i & (cpu_req_o.rd | (|cpu_req_o.wr)));

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            pend_q        <= 1'b0;
            load_fault_q  <= 1'b0;
            store_fault_q <= 1'b0;
            tlb_q         <= '0;
        end
        else
        begin
            pend_q        <= valid_w & ~lsu_accept_o;
            load_fault_q  <= load_fault_w;
            store_fault_q <= store_fault_w;
            if (flush_i)
                tlb_q.valid <= 1'b0;
            else if (refill_i)
                tlb_q <= refill_entry_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (valid_w)
            req_q <= cur_w;
        // Faulting access answers with its own tag
        if (load_fault_w || store_fault_w)
            fault_tag_q <= cur_w.tag;
    end

    //------------------------------------------------------------------
    // Core response
    //------------------------------------------------------------------
    assign fault_rsp_w = load_fault_q | store_fault_q;

    assign lsu_rsp_o.rsp.ack     = cpu_rsp_i.ack | fault_rsp_w;
    assign lsu_rsp_o.rsp.error   = cpu_rsp_i.error | fault_rsp_w;
    assign lsu_rsp_o.rsp.data    = cpu_rsp_i.data;
    assign lsu_rsp_o.rsp.tag     = fault_rsp_w ? fault_tag_q : cpu_rsp_i.tag;
    assign lsu_rsp_o.load_fault  = load_fault_q;
    assign lsu_rsp_o.store_fault = store_fault_q;

    assign miss_o      = valid_w & vm_en_w & ~hit_w;
    assign miss_addr_o = cur_w.addr;

endmodule

//--- hw/fetch_translate.sv
// Instruction address translation
module fetch_translate
(
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  sv32_pkg::satp_t          satp_i,
    input  logic                     flush_i,
    input  mem_port_pkg::fetch_req_t fetch_req_i,
    input  logic                     fetch_out_accept_i,
    input  logic                     refill_i,
    input  sv32_pkg::tlb_entry_t     refill_entry_i,
    output logic                     fetch_accept_o,
    output mem_port_pkg::fetch_out_t fetch_out_o,
    output logic                     fetch_fault_o,
    output logic                     miss_o,
    output logic [31:0]              miss_addr_o
);
    import sv32_pkg::*;

    tlb_entry_t tlb_q;
    logic       vm_en_w;
    logic       hit_w;
    logic       fault_w;
    logic       fault_q;

    // Machine mode always fetches physical addresses
    assign vm_en_w = satp_i.mode & (fetch_req_i.priv != PRIV_MACHINE);
    assign hit_w   = fetch_req_i.rd & tlb_q.valid &
                     (tlb_q.vtag == fetch_req_i.pc[31:PAGE_OFFSET_W]);

    //------------------------------------------------------------------
    // TLB entry
    //------------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            tlb_q <= '0;
        else if (flush_i)
            tlb_q.valid <= 1'b0;
        else if (refill_i)
        begin
            // Drop the entry if the fetch has moved on to another page
            tlb_q <= '{valid: refill_entry_i.valid &
                              (refill_entry_i.vtag == fetch_req_i.pc[31:PAGE_OFFSET_W]),
                       vtag:  refill_entry_i.vtag,
                       pte:   refill_entry_i.pte};
        end
    end

    //------------------------------------------------------------------
    // Execute permission
    //------------------------------------------------------------------
    always_comb
    begin
        fault_w = 1'b0;
        if (vm_en_w && hit_w)
        begin
            // Supervisor never executes from user pages
            if (fetch_req_i.priv == PRIV_SUPER)
                fault_w = tlb_q.pte.flags.u | ~tlb_q.pte.flags.x;
            else
                fault_w = ~tlb_q.pte.flags.u | ~tlb_q.pte.flags.x;
        end
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            fault_q <= 1'b0;
        else
            fault_q <= fault_w;
    end

    assign fetch_out_o.rd = fetch_req_i.rd & (~vm_en_w | (hit_w & ~fault_w));
    assign fetch_out_o.pc = vm_en_w ?
        {tlb_q.pte.ppn1[VPN_W-1:0], tlb_q.pte.ppn0, fetch_req_i.pc[PAGE_OFFSET_W-1:0]} :
        fetch_req_i.pc;

    // A fault consumes the fetch without passing it on
    assign fetch_accept_o = fault_w | (fetch_out_o.rd & fetch_out_accept_i);
    assign fetch_fault_o  = fault_q;

    assign miss_o      = fetch_req_i.rd & vm_en_w & ~hit_w;
    assign miss_addr_o = fetch_req_i.pc;

endmodule

//--- hw/mem_port_pkg.sv
// Core and memory port formats
package mem_port_pkg;

    localparam int TAG_W = 11;

    // Tag reserved for page table reads
    localparam logic [TAG_W-1:0] WALK_TAG = {1'b0, 3'b111, 7'b0};

    typedef struct packed
    {
        logic                rd;
        logic [31:0]         pc;
        sv32_pkg::priv_t     priv;
    } fetch_req_t;

    typedef struct packed
    {
        logic         rd;
        logic [31:0]  pc;
    } fetch_out_t;

    // Core load/store request, also the memory request
    typedef struct packed
    {
        logic              rd;
        logic [3:0]        wr;
        logic [31:0]       addr;
        logic [31:0]       data_wr;
        logic [TAG_W-1:0]  tag;
    } lsu_req_t;

    typedef struct packed
    {
        logic              ack;
        logic              error;
        logic [31:0]       data;
        logic [TAG_W-1:0]  tag;
    } mem_rsp_t;

    typedef struct packed
    {
        mem_rsp_t  rsp;
        logic      load_fault;
        logic      store_fault;
    } lsu_rsp_t;

    typedef struct packed
    {
        logic         valid;
        logic         error;
        logic [31:0]  data;
    } walk_rsp_t;

endpackage

//--- hw/sv32_pkg.sv
// Sv32 page table formats
package sv32_pkg;

    // Address split
    localparam int PAGE_OFFSET_W   = 12;
    localparam int VPN_W           = 10;
    localparam int PPN_W           = 22;
    localparam int PTE_BYTES_SHIFT = 2;

    typedef enum logic [1:0]
    {
        PRIV_USER    = 2'd0,
        PRIV_SUPER   = 2'd1,
        PRIV_MACHINE = 2'd3
    } priv_t;

    typedef struct packed
    {
        logic              mode;
        logic [8:0]        asid;
        logic [PPN_W-1:0]  ppn;
    } satp_t;

    typedef struct packed
    {
        logic [VPN_W-1:0]          vpn1;
        logic [VPN_W-1:0]          vpn0;
        logic [PAGE_OFFSET_W-1:0]  offset;
    } vaddr_t;

    // Low ten bits of a PTE
    typedef struct packed
    {
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_flags_t;

    typedef struct packed
    {
        logic [PPN_W-VPN_W-1:0]  ppn1;
        logic [VPN_W-1:0]        ppn0;
        pte_flags_t              flags;
    } pte_t;

    // All-zero pte marks a faulting walk
    typedef struct packed
    {
        logic                   valid;
        logic [2*VPN_W-1:0]     vtag;
        pte_t                   pte;
    } tlb_entry_t;

endpackage
